// ==== hw/mpdmac_defs.svh ====
// Geometry and bus width constants of the mirror-padding DMA engine
// Block edge is fixed at 4, so N must be a multiple of 4 within the width limits
`ifndef MPDMAC_DEFS_SVH
`define MPDMAC_DEFS_SVH

// Source block edge and block buffer edge (block plus one pad cell)
`define MPDMAC_BLK          4
`define MPDMAC_BUF          5

// Legal matrix width range, N=4 would make one block two corner types
`define MPDMAC_MIN_WIDTH    8
`define MPDMAC_MAX_WIDTH    60
`define MPDMAC_WIDTH_BITS   6

// AXI field widths
`define AXI_ADDR_BITS       32
`define AXI_DATA_BITS       32
`define AXI_LEN_BITS        4

// Bytes per beat, fixed 4-byte INCR transfers
`define AXI_WORD_BYTES      4

`endif

// ==== hw/axi_pkg.sv ====
// AXI field types of the engine read and write ports
// Size, burst type and strobes are implied constants and have no type here
`default_nettype none

`include "mpdmac_defs.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_BITS-1:0] addr_t;  // Byte address
    typedef logic [`AXI_DATA_BITS-1:0] data_t;  // One beat

    // Burst length, beats minus one
    typedef logic [`AXI_LEN_BITS-1:0]  len_t;

endpackage

`default_nettype wire

// ==== hw/mpdmac_pkg.sv ====
// Engine state and block-position types
// Position encoding assumes a block never touches both top and bottom edges
`default_nettype none

`include "mpdmac_defs.svh"

package mpdmac_pkg;

    typedef logic [`MPDMAC_WIDTH_BITS-1:0] width_t;

    // Width divided by the block edge
    typedef logic [`MPDMAC_WIDTH_BITS-3:0] blk_idx_t;

    // Where a block sits in the block grid
    typedef enum logic [3:0] {
        POS_TL, POS_TR, POS_BL, POS_BR,
        POS_TOP, POS_BOTTOM, POS_LEFT, POS_RIGHT,
        POS_INNER
    } blk_pos_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_RD_REQ, ST_RD_DATA, ST_PAD,
        ST_WR_REQ, ST_WR_DATA, ST_WR_RESP
    } state_e;

endpackage

`default_nettype wire

// ==== hw/mpdmac_cfg.sv ====
// Start qualification and run parameters
// A start is taken only while done is high and N is a legal multiple of 4
`default_nettype none

`include "mpdmac_defs.svh"

module mpdmac_cfg (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  axi_pkg::addr_t        src_addr_i,
    input  axi_pkg::addr_t        dst_addr_i,
    input  mpdmac_pkg::width_t    width_i,
    input  wire                   finish_i,
    output logic                  go_o,
    output axi_pkg::addr_t        src_addr_o,
    output axi_pkg::addr_t        dst_addr_o,
    output mpdmac_pkg::width_t    width_o,
    output mpdmac_pkg::blk_idx_t  blocks_o,
    output logic                  done_o
);

    logic width_ok;
    logic accept;

    assign width_ok = (width_i >= `MPDMAC_MIN_WIDTH) && (width_i <= `MPDMAC_MAX_WIDTH)
                   && (width_i % `MPDMAC_BLK == 0);
    assign accept   = start_i && done_o && width_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            go_o   <= 1'b0;
            done_o <= 1'b1;  // Idle engine reports done
        end else begin
            go_o <= accept;
            if (accept)
                done_o <= 1'b0;
            else if (finish_i)
                done_o <= 1'b1;
        end
    end

    // Run parameters held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            src_addr_o <= src_addr_i;
            dst_addr_o <= dst_addr_i;
            width_o    <= width_i;
            blocks_o   <= mpdmac_pkg::blk_idx_t'(width_i / `MPDMAC_BLK);
        end
    end

endmodule

`default_nettype wire

// ==== hw/mpdmac_ctrl.sv ====
// Block walker and AXI sequencer, one burst outstanding at a time
// Reads four 4-beat rows per block, pads for one cycle, then writes one burst per row
// Response codes are not checked
`default_nettype none

`include "mpdmac_defs.svh"

module mpdmac_ctrl (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   go_i,
    input  axi_pkg::addr_t        src_addr_i,
    input  axi_pkg::addr_t        dst_addr_i,
    input  mpdmac_pkg::width_t    width_i,
    input  mpdmac_pkg::blk_idx_t  blocks_i,
    input  wire                   arready_i,
    input  wire                   rlast_i,
    input  wire                   rvalid_i,
    input  wire                   awready_i,
    input  wire                   wready_i,
    input  wire                   bvalid_i,
    output logic                  finish_o,
    output mpdmac_pkg::blk_pos_e  blk_pos_o,
    output logic                  load_o,
    output logic [1:0]            load_row_o,
    output logic [1:0]            load_col_o,
    output logic                  pad_o,
    output logic [2:0]            win_row_o,
    output logic [2:0]            win_col_o,
    output axi_pkg::addr_t        araddr_o,
    output logic                  arvalid_o,
    output logic                  rready_o,
    output axi_pkg::addr_t        awaddr_o,
    output axi_pkg::len_t         awlen_o,
    output logic                  awvalid_o,
    output logic                  wlast_o,
    output logic                  wvalid_o,
    output logic                  bready_o
);

    mpdmac_pkg::state_e   state;
    mpdmac_pkg::blk_idx_t bx, by;
    mpdmac_pkg::blk_idx_t last_idx;
    logic [1:0]           rd_row, rd_col;
    logic [2:0]           wr_row, wr_col;
    logic [2:0]           win_rows, win_cols;
    logic                 top, bottom, left, right;
    logic                 last_blk;
    axi_pkg::addr_t       rd_elem, wr_prow, wr_pcol, wr_elem;

    assign last_idx = blocks_i - 4'd1;
    assign top      = (by == 0);
    assign bottom   = (by == last_idx);
    assign left     = (bx == 0);
    assign right    = (bx == last_idx);
    assign last_blk = right && bottom;

    // Own 4x4 plus any border pad row or column
    assign win_rows = 3'(`MPDMAC_BLK) + {2'b00, top} + {2'b00, bottom};
    assign win_cols = 3'(`MPDMAC_BLK) + {2'b00, left} + {2'b00, right};

    always_comb begin
        if (top && left)       blk_pos_o = mpdmac_pkg::POS_TL;
        else if (top && right) blk_pos_o = mpdmac_pkg::POS_TR;
        else if (bottom && left)  blk_pos_o = mpdmac_pkg::POS_BL;
        else if (bottom && right) blk_pos_o = mpdmac_pkg::POS_BR;
        else if (top)          blk_pos_o = mpdmac_pkg::POS_TOP;
        else if (bottom)       blk_pos_o = mpdmac_pkg::POS_BOTTOM;
        else if (left)         blk_pos_o = mpdmac_pkg::POS_LEFT;
        else if (right)        blk_pos_o = mpdmac_pkg::POS_RIGHT;
        else                   blk_pos_o = mpdmac_pkg::POS_INNER;
    end

    // Source word index of the current read row
    assign rd_elem = (axi_pkg::addr_t'(by) * `MPDMAC_BLK + axi_pkg::addr_t'(rd_row))
                   * axi_pkg::addr_t'(width_i) + axi_pkg::addr_t'(bx) * `MPDMAC_BLK;
    assign araddr_o = src_addr_i + rd_elem * `AXI_WORD_BYTES;

    // Window origin in the padded matrix backs off by one at a top or left edge
    assign wr_prow = axi_pkg::addr_t'(by) * `MPDMAC_BLK + (top ? 32'd0 : 32'd1)
                   + axi_pkg::addr_t'(wr_row);
    assign wr_pcol = axi_pkg::addr_t'(bx) * `MPDMAC_BLK + (left ? 32'd0 : 32'd1);
    assign wr_elem = wr_prow * (axi_pkg::addr_t'(width_i) + 32'd2) + wr_pcol;
    assign awaddr_o = dst_addr_i + wr_elem * `AXI_WORD_BYTES;
    assign awlen_o  = axi_pkg::len_t'(win_cols - 3'd1);

    assign arvalid_o = (state == mpdmac_pkg::ST_RD_REQ);
    assign rready_o  = (state == mpdmac_pkg::ST_RD_DATA);
    assign awvalid_o = (state == mpdmac_pkg::ST_WR_REQ);
    assign wvalid_o  = (state == mpdmac_pkg::ST_WR_DATA);
    assign bready_o  = (state == mpdmac_pkg::ST_WR_RESP);
    assign wlast_o   = wvalid_o && (wr_col == win_cols - 3'd1);

    assign load_o     = rready_o && rvalid_i;  // Every R beat lands in the buffer
    assign load_row_o = rd_row;
    assign load_col_o = rd_col;
    assign pad_o      = (state == mpdmac_pkg::ST_PAD);
    assign win_row_o  = wr_row;
    assign win_col_o  = wr_col;

    assign finish_o = bready_o && bvalid_i && (wr_row == win_rows - 3'd1) && last_blk;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= mpdmac_pkg::ST_IDLE;
            bx     <= '0;
            by     <= '0;
            rd_row <= '0;
            rd_col <= '0;
            wr_row <= '0;
            wr_col <= '0;
        end else begin
            case (state)
                mpdmac_pkg::ST_IDLE: begin
                    if (go_i) begin
                        bx     <= '0;
                        by     <= '0;
                        rd_row <= '0;
                        rd_col <= '0;
                        state  <= mpdmac_pkg::ST_RD_REQ;
                    end
                end
                mpdmac_pkg::ST_RD_REQ: begin
                    if (arready_i)
                        state <= mpdmac_pkg::ST_RD_DATA;
                end
                mpdmac_pkg::ST_RD_DATA: begin
                    if (rvalid_i) begin
                        rd_col <= rd_col + 2'd1;
                        if (rlast_i) begin
                            rd_col <= '0;
                            if (rd_row == 2'd3) begin
                                state <= mpdmac_pkg::ST_PAD;
                            end else begin
                                rd_row <= rd_row + 2'd1;
                                state  <= mpdmac_pkg::ST_RD_REQ;
                            end
                        end
                    end
                end
                mpdmac_pkg::ST_PAD: begin
                    wr_row <= '0;
                    state  <= mpdmac_pkg::ST_WR_REQ;
                end
                mpdmac_pkg::ST_WR_REQ: begin
                    if (awready_i) begin
                        wr_col <= '0;
                        state  <= mpdmac_pkg::ST_WR_DATA;
                    end
                end
                mpdmac_pkg::ST_WR_DATA: begin
                    if (wready_i) begin
                        wr_col <= wr_col + 3'd1;
                        if (wlast_o)
                            state <= mpdmac_pkg::ST_WR_RESP;
                    end
                end
                mpdmac_pkg::ST_WR_RESP: begin
                    if (bvalid_i) begin
                        if (wr_row != win_rows - 3'd1) begin
                            wr_row <= wr_row + 3'd1;  // Next window row
                            state  <= mpdmac_pkg::ST_WR_REQ;
                        end else if (last_blk) begin
                            state <= mpdmac_pkg::ST_IDLE;
                        end else begin
                            // Row-major block walk
                            if (right) begin
                                bx <= '0;
                                by <= by + 4'd1;
                            end else begin
                                bx <= bx + 4'd1;
                            end
                            rd_row <= '0;
                            state  <= mpdmac_pkg::ST_RD_REQ;
                        end
                    end
                end
                default: state <= mpdmac_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/mpdmac_buffer.sv ====
// 5x5 block buffer, source cells sit at (top, left) so the write window starts at (0,0)
// Pad copies read the pre-pad contents, load and pad never overlap in time
`default_nettype none

`include "mpdmac_defs.svh"

module mpdmac_buffer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  mpdmac_pkg::blk_pos_e  blk_pos_i,
    input  wire                   load_i,
    input  wire  [1:0]            load_row_i,
    input  wire  [1:0]            load_col_i,
    input  axi_pkg::data_t        rdata_i,
    input  wire                   pad_i,
    input  wire  [2:0]            win_row_i,
    input  wire  [2:0]            win_col_i,
    output axi_pkg::data_t        rd_word_o
);

    axi_pkg::data_t mem [0:`MPDMAC_BUF-1][0:`MPDMAC_BUF-1];  // [row][col]

    logic       top, bottom, left, right;
    logic [2:0] pad_row, pad_col;

    assign top    = blk_pos_i inside {mpdmac_pkg::POS_TL, mpdmac_pkg::POS_TR,
                                      mpdmac_pkg::POS_TOP};
    assign bottom = blk_pos_i inside {mpdmac_pkg::POS_BL, mpdmac_pkg::POS_BR,
                                      mpdmac_pkg::POS_BOTTOM};
    assign left   = blk_pos_i inside {mpdmac_pkg::POS_TL, mpdmac_pkg::POS_BL,
                                      mpdmac_pkg::POS_LEFT};
    assign right  = blk_pos_i inside {mpdmac_pkg::POS_TR, mpdmac_pkg::POS_BR,
                                      mpdmac_pkg::POS_RIGHT};

    // Pad row or column lands on whichever side the data left free
    assign pad_row = top  ? 3'd0 : 3'd4;
    assign pad_col = left ? 3'd0 : 3'd4;

    always_ff @(posedge clk) begin
        if (rst_n) begin  // No writes while in reset
            if (load_i) begin
                mem[{2'b00, top} + {1'b0, load_row_i}][{2'b00, left} + {1'b0, load_col_i}]
                    <= rdata_i;
            end else if (pad_i) begin
                // Buffer row 2 always holds source row 1 or N-2
                if (top || bottom) begin
                    for (int c = 0; c < `MPDMAC_BUF; c++)
                        mem[pad_row][c] <= mem[2][c];
                end
                if (left || right) begin
                    for (int r = 0; r < `MPDMAC_BUF; r++)
                        mem[r][pad_col] <= mem[r][2];
                end
                // Corner overrides both copies above
                if ((top || bottom) && (left || right))
                    mem[pad_row][pad_col] <= mem[2][2];
            end
        end
    end

    assign rd_word_o = mem[win_row_i][win_col_i];

endmodule

`default_nettype wire

// ==== hw/mpdmac_top.sv ====
// Mirror-padding DMA engine top
// Slave must assume 4-byte INCR bursts with all strobes set and 4-beat reads
`default_nettype none

module mpdmac_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  axi_pkg::addr_t        src_addr_i,
    input  axi_pkg::addr_t        dst_addr_i,
    input  mpdmac_pkg::width_t    width_i,
    output logic                  done_o,
    output axi_pkg::addr_t        araddr_o,
    output logic                  arvalid_o,
    input  wire                   arready_i,
    input  axi_pkg::data_t        rdata_i,
    input  wire                   rlast_i,
    input  wire                   rvalid_i,
    output logic                  rready_o,
    output axi_pkg::addr_t        awaddr_o,
    output axi_pkg::len_t         awlen_o,
    output logic                  awvalid_o,
    input  wire                   awready_i,
    output axi_pkg::data_t        wdata_o,
    output logic                  wlast_o,
    output logic                  wvalid_o,
    input  wire                   wready_i,
    input  wire                   bvalid_i,
    output logic                  bready_o
);

    logic                 go, finish;
    axi_pkg::addr_t       src_addr, dst_addr;
    mpdmac_pkg::width_t   width;
    mpdmac_pkg::blk_idx_t blocks;
    mpdmac_pkg::blk_pos_e blk_pos;
    logic                 load, pad;
    logic [1:0]           load_row, load_col;
    logic [2:0]           win_row, win_col;

    mpdmac_cfg u_cfg (
        .clk(clk), .rst_n(rst_n), .start_i(start_i),
        .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i), .width_i(width_i),
        .finish_i(finish), .go_o(go), .src_addr_o(src_addr), .dst_addr_o(dst_addr),
        .width_o(width), .blocks_o(blocks), .done_o(done_o)
    );

    mpdmac_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .go_i(go),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .width_i(width), .blocks_i(blocks),
        .arready_i(arready_i), .rlast_i(rlast_i), .rvalid_i(rvalid_i),
        .awready_i(awready_i), .wready_i(wready_i), .bvalid_i(bvalid_i),
        .finish_o(finish), .blk_pos_o(blk_pos), .load_o(load),
        .load_row_o(load_row), .load_col_o(load_col), .pad_o(pad),
        .win_row_o(win_row), .win_col_o(win_col),
        .araddr_o(araddr_o), .arvalid_o(arvalid_o), .rready_o(rready_o),
        .awaddr_o(awaddr_o), .awlen_o(awlen_o), .awvalid_o(awvalid_o),
        .wlast_o(wlast_o), .wvalid_o(wvalid_o), .bready_o(bready_o)
    );

    // Buffer word feeds the W channel directly
    mpdmac_buffer u_buffer (
        .clk(clk), .rst_n(rst_n), .blk_pos_i(blk_pos),
        .load_i(load), .load_row_i(load_row), .load_col_i(load_col), .rdata_i(rdata_i),
        .pad_i(pad), .win_row_i(win_row), .win_col_i(win_col), .rd_word_o(wdata_o)
    );

endmodule

`default_nettype wire

// ==== tb/axi_slave_mem.sv ====
// AXI memory slave for the testbench, one burst at a time per channel
// Reads are always 4 beats, writes end on wlast, 4-byte INCR and full strobes assumed
// Ready and valid outputs drop at random, stall_pct_i out of 100 cycles on average
`default_nettype none

module axi_slave_mem #(
    parameter int mem_words = 16384
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [6:0]  stall_pct_i,
    input  wire  [31:0] araddr_i,
    input  wire         arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic        rlast_o,
    output logic        rvalid_o,
    input  wire         rready_i,
    input  wire  [31:0] awaddr_i,
    input  wire         awvalid_i,
    output logic        awready_o,
    input  wire  [31:0] wdata_i,
    input  wire         wlast_i,
    input  wire         wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  wire         bready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [0:mem_words-1];
    logic        rd_busy, wr_busy, b_pend;
    logic [2:0]  rd_beat;
    logic [3:0]  wr_beat;
    int          rd_base, wr_base;

    function automatic bit no_stall();
        return ($urandom % 100) >= stall_pct_i;
    endfunction

    // Outputs known before the first clock edge
    initial begin
        arready_o <= 1'b0;
        rdata_o   <= '0;
        rlast_o   <= 1'b0;
        rvalid_o  <= 1'b0;
        awready_o <= 1'b0;
        wready_o  <= 1'b0;
        bvalid_o  <= 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rlast_o   <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            rd_busy   <= 1'b0;
            wr_busy   <= 1'b0;
            b_pend    <= 1'b0;
        end else begin
            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                rd_busy   <= 1'b1;
                rd_base   <= int'(araddr_i >> 2);  // Word index
                rd_beat   <= '0;
            end else begin
                arready_o <= !rd_busy && no_stall();
            end

            // One idle cycle at least between R beats
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                rd_beat  <= rd_beat + 3'd1;
                if (rlast_o)
                    rd_busy <= 1'b0;
            end else if (rd_busy && !rvalid_o && no_stall()) begin
                rvalid_o <= 1'b1;
                rdata_o  <= mem[(rd_base + int'(rd_beat)) % mem_words];
                rlast_o  <= (rd_beat == 3'd3);
            end

            if (awvalid_i && awready_o) begin
                awready_o <= 1'b0;
                wr_busy   <= 1'b1;
                wr_base   <= int'(awaddr_i >> 2);
                wr_beat   <= '0;
            end else begin
                awready_o <= !wr_busy && !b_pend && no_stall();
            end

            if (wvalid_i && wready_o) begin
                mem[(wr_base + int'(wr_beat)) % mem_words] <= wdata_i;
                wr_beat <= wr_beat + 4'd1;
                if (wlast_i) begin
                    wr_busy  <= 1'b0;
                    b_pend   <= 1'b1;
                    wready_o <= 1'b0;
                end else begin
                    wready_o <= no_stall();
                end
            end else begin
                wready_o <= wr_busy && no_stall();
            end

            // Response only after the last W beat
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                b_pend   <= 1'b0;
            end else if (b_pend && !bvalid_o && no_stall()) begin
                bvalid_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_mpdmac.sv ====
// Testbench for the mirror-padding DMA engine
// Run from the project root so the case file path resolves
// Case addresses must leave room for a guard word on each side of the destination
`default_nettype none

module tb_mpdmac;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          mem_words  = 16384;
    localparam int          max_cases  = 16;
    localparam int          done_limit = 200000;
    localparam logic [31:0] sentinel   = 32'h5a5a_c3c3;

    logic        clk = 1'b0;
    logic        rst_n, start_i;
    logic [31:0] src_addr_i, dst_addr_i;
    logic [5:0]  width_i;
    logic [6:0]  stall_pct;
    logic        done, arvalid, arready, rlast, rvalid, rready;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [3:0]  awlen;

    logic [31:0] case_words [0:4*max_cases-1];
    logic [31:0] src_copy [0:3599];  // Source words of the current case
    int          errors = 0;
    int          wbeats = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          burst_len = 0;
    int          burst_beat = 0;
    bit          aborted = 1'b0;

    mpdmac_top DUT (
        .clk(clk), .rst_n(rst_n), .start_i(start_i),
        .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i), .width_i(width_i), .done_o(done),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awlen_o(awlen), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_slave_mem #(.mem_words(mem_words)) slave (
        .clk(clk), .rst_n(rst_n), .stall_pct_i(stall_pct),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready)
    );

    always #10 clk = ~clk;

    // Completed W beats
    always @(posedge clk)
        if (wvalid && wready)
            wbeats <= wbeats + 1;

    // Window is 5 columns wide at the left and right matrix edges, 4 elsewhere
    always @(negedge clk) begin
        int col;
        int exp_len;
        if (awvalid && awready) begin
            col     = int'((awaddr - dst_addr_i) >> 2) % (int'(width_i) + 2);
            exp_len = (col == 0 || col == int'(width_i) - 3) ? 5 : 4;
            compare("awlen_o", 32'(awlen), 32'(exp_len - 1));
            burst_len  <= exp_len;
            burst_beat <= 0;
        end
        if (wvalid && wready) begin
            compare("wlast_o", 32'(wlast), 32'(burst_beat == burst_len - 1));
            burst_beat <= burst_beat + 1;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_done(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (done !== level && cycles < limit);
        if (done !== level) begin
            $display("Timeout after %0d cycles waiting for %s", limit, what);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic report(input string what, input int errs0);
        if (errors == errs0) begin
            n_pass++;
            $display("%s: ok", what);
        end else begin
            n_fail++;
            $display("%s: FAIL", what);
        end
    endtask

    function automatic bit width_legal(input int n);
        return (n % 4 == 0) && (n >= 8) && (n <= 60);
    endfunction

    // Reflection without the edge element
    function automatic int mirror(input int k, input int n);
        if (k < 0)
            return 1;
        if (k >= n)
            return n - 2;
        return k;
    endfunction

    task automatic run_transfer(input int n, input logic [31:0] src, input logic [31:0] dst,
                                input int stall);
        int          s0, d0, pw, beats0;
        logic [31:0] word;
        s0 = int'(src >> 2);
        d0 = int'(dst >> 2);
        pw = n + 2;
        for (int i = 0; i < mem_words; i++) begin
            word = $urandom ^ (i * 32'h9e37_79b9);
            if (i >= s0 && i < s0 + n * n)
                src_copy[i - s0] = word;
            slave.mem[i] <= word;
        end
        slave.mem[d0 - 1]       <= sentinel;
        slave.mem[d0 + pw * pw] <= sentinel;
        @(posedge clk);
        stall_pct  <= 7'(stall);
        src_addr_i <= src;
        dst_addr_i <= dst;
        width_i    <= 6'(n);
        start_i    <= 1'b1;
        beats0 = wbeats;
        @(posedge clk);
        start_i <= 1'b0;
        wait_done(1'b0, 4, "done_o to fall after an accepted start");
        if (aborted)
            return;
        wait_done(1'b1, done_limit, "done_o to rise at the end of the transfer");
        if (aborted)
            return;
        compare("W beat count", 32'(wbeats - beats0), 32'(pw * pw));
        for (int r = 0; r < pw; r++)
            for (int c = 0; c < pw; c++)
                compare($sformatf("dst[%0d][%0d]", r, c), slave.mem[d0 + r * pw + c],
                        src_copy[mirror(r - 1, n) * n + mirror(c - 1, n)]);
        for (int i = 0; i < n * n; i++)
            compare($sformatf("src[%0d]", i), slave.mem[s0 + i], src_copy[i]);
        compare("guard below dst", slave.mem[d0 - 1], sentinel);
        compare("guard above dst", slave.mem[d0 + pw * pw], sentinel);
    endtask

    task automatic run_rejected(input int n);
        @(posedge clk);
        width_i <= 6'(n);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        repeat (50) begin
            @(negedge clk);
            compare("done_o", 32'(done), 32'd1);
            compare("arvalid_o", 32'(arvalid), 32'd0);
        end
    endtask

    initial begin
        int n_cases;
        int n;
        int errs0;
        void'($urandom(32'h83060b77));
        rst_n      <= 1'b0;
        start_i    <= 1'b0;
        src_addr_i <= '0;
        dst_addr_i <= '0;
        width_i    <= '0;
        stall_pct  <= '0;
        for (int i = 0; i < 4 * max_cases; i++)
            case_words[i] = '1;  // All ones marks the end of the list
        $readmemh("tb/mpdmac_cases.txt", case_words);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        errs0 = errors;
        compare("done_o", 32'(done), 32'd1);
        compare("arvalid_o", 32'(arvalid), 32'd0);
        compare("rready_o", 32'(rready), 32'd0);
        compare("awvalid_o", 32'(awvalid), 32'd0);
        compare("wvalid_o", 32'(wvalid), 32'd0);
        compare("bready_o", 32'(bready), 32'd0);
        report("reset state", errs0);

        n_cases = 0;
        while (n_cases < max_cases && case_words[4 * n_cases] !== 32'hffff_ffff)
            n_cases++;
        if (n_cases == 0) begin
            $display("No cases could be read from tb/mpdmac_cases.txt");
            errors++;
        end

        for (int t = 0; t < n_cases && !aborted; t++) begin
            n = int'(case_words[4 * t]);
            errs0 = errors;
            if (width_legal(n))
                run_transfer(n, case_words[4 * t + 1], case_words[4 * t + 2],
                             int'(case_words[4 * t + 3]));
            else
                run_rejected(n);
            report($sformatf("test %0d width %0d stall %0d%%", t, n, case_words[4 * t + 3]),
                   errs0);
        end

        $display("%0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/mpdmac_cases.txt ====
// width  src_addr  dst_addr  stall_pct, all hex, addresses in bytes
// Widths that are not a multiple of 4 in 8..60 must leave the engine idle
08 00000000 00004000 00
0c 00001000 00008000 00
10 00002000 0000c000 00
3c 00000000 00008000 00
00 00000000 00004000 00
06 00000000 00004000 00
0a 00000000 00004000 00
08 00003000 00004000 1e
0c 00000400 00006000 32
10 00001000 0000a000 46
3c 00000000 00008000 28

// ==== vlog.f ====
+incdir+hw
hw/axi_pkg.sv
hw/mpdmac_pkg.sv
hw/mpdmac_cfg.sv
hw/mpdmac_ctrl.sv
hw/mpdmac_buffer.sv
hw/mpdmac_top.sv
tb/axi_slave_mem.sv
tb/tb_mpdmac.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = tb_mpdmac
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
